//--- verilog.f
+incdir+include
design/fifo_pkg.sv
design/fifo_dpram.sv
design/fifo_write_ctrl.sv
design/fifo_read_ctrl.sv
design/fifo_status.sv
design/fifo_width_down.sv
tb/tb_clock_gen.sv
tb/tb_fifo_width_down.sv

//--- Bender.yml
package:
  name: fifo_width_down

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/fifo_pkg.sv
      - design/fifo_dpram.sv
      - design/fifo_write_ctrl.sv
      - design/fifo_read_ctrl.sv
      - design/fifo_status.sv
      - design/fifo_width_down.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_fifo_width_down.sv

//--- tb/tb_fifo_width_down.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

module tb_fifo_width_down import fifo_pkg::*; ();

    localparam int RESET_TIMEOUT = 10;
    localparam int VALID_TIMEOUT = 8;
    localparam int FILL_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT = 300;
    localparam int RANDOM_CYCLES = 2000;

    logic clock;
    logic reset;
    logic wr_en;
    wide_word_t din;
    logic rd_en;
    logic wr_ready;
    logic wr_ack;
    logic valid;
    narrow_word_t dout;
    logic full;
    logic empty;
    logic almost_full;
    logic almost_empty;
    logic prog_full;
    logic prog_empty;
    logic overflow;
    logic underflow;
    word_count_t wr_data_count;
    word_count_t wr_data_space;
    item_count_t rd_data_count;

    // byte stream model, front is the next item the reader must see
    narrow_word_t model_q[$];
    // words waiting in the ram, and unread items of the presented word
    int model_words;
    int model_held;
    int unsigned writes_accepted;
    logic exp_overflow;
    logic exp_underflow;
    logic [31:0] rng_state;
    logic [31:0] traffic;
    int cycles;

    tb_clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    fifo_width_down fifo_width_down_i (
        .clock         (clock),
        .reset         (reset),
        .wr_en         (wr_en),
        .din           (din),
        .rd_en         (rd_en),
        .wr_ready      (wr_ready),
        .wr_ack        (wr_ack),
        .valid         (valid),
        .dout          (dout),
        .full          (full),
        .empty         (empty),
        .almost_full   (almost_full),
        .almost_empty  (almost_empty),
        .prog_full     (prog_full),
        .prog_empty    (prog_empty),
        .overflow      (overflow),
        .underflow     (underflow),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "wait loop timed out");
    endtask

    // outputs are sampled at the falling edge, mid cycle
    task automatic check_outputs();
        int n;
        int i;
        logic exp_ready;
        logic exp_valid;
        logic accept;
        logic consume;
        logic fetch;
        n = model_q.size();
        exp_ready = (model_words != `FIFO_DEPTH);
        exp_valid = (model_held != 0);
        check_value("rd_data_count", rd_data_count, n);
        check_value("wr_data_count", wr_data_count, model_words);
        check_value("wr_data_count + wr_data_space",
                    32'(wr_data_count) + 32'(wr_data_space), `FIFO_DEPTH);
        check_value("full", full, !exp_ready);
        check_value("wr_ready", wr_ready, exp_ready);
        check_value("wr_ack", wr_ack, wr_en && exp_ready);
        check_value("valid", valid, exp_valid);
        check_value("empty", empty, n == 0);
        check_value("almost_empty", almost_empty, n <= 1);
        check_value("prog_empty", prog_empty, n <= `FIFO_PROG_EMPTY_THRESH);
        check_value("almost_full", almost_full, model_words >= `FIFO_DEPTH - 1);
        check_value("prog_full", prog_full, model_words >= `FIFO_PROG_FULL_THRESH);
        check_value("overflow", overflow, exp_overflow);
        check_value("underflow", underflow, exp_underflow);
        // fwft, presented item is the oldest unread byte
        if (exp_valid) begin
            check_value("dout", dout, model_q[0]);
        end
        // what the next rising edge will do with the current inputs
        accept = wr_en && exp_ready;
        consume = rd_en && exp_valid;
        // a stored word moves up when nothing is presented
        // or when the last item of the presented word leaves
        fetch = (model_words != 0)
                && ((model_held == 0) || (consume && model_held == 1));
        if (consume) begin
            void'(model_q.pop_front());
        end
        if (fetch) begin
            model_words--;
            model_held = `FIFO_LANES;
        end else if (consume) begin
            model_held--;
        end
        if (accept) begin
            writes_accepted++;
            model_words++;
            // top byte goes out first
            for (i = `FIFO_LANES - 1; i >= 0; i--) begin
                model_q.push_back(din[i * `FIFO_OUT_WIDTH +: `FIFO_OUT_WIDTH]);
            end
        end
        exp_overflow = wr_en && !exp_ready;
        exp_underflow = rd_en && !exp_valid;
    endtask

    task automatic run_cycle(input logic w, input logic r, input wide_word_t d);
        @(posedge clock);
        wr_en <= w;
        rd_en <= r;
        din <= d;
        @(negedge clock);
        check_outputs();
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        wr_en = 1'b0;
        rd_en = 1'b0;
        din = '0;
        model_words = 0;
        model_held = 0;
        writes_accepted = 0;
        exp_overflow = 1'b0;
        exp_underflow = 1'b0;
        rng_state = 32'd70785;
        traffic = '0;

        cycles = 0;
        @(negedge clock);
        while (reset) begin
            if (cycles >= RESET_TIMEOUT) report_timeout("reset was never released");
            @(negedge clock);
            cycles++;
        end

        // reset values, nothing written yet
        check_value("valid", valid, 1'b0);
        check_value("overflow", overflow, 1'b0);
        check_value("underflow", underflow, 1'b0);
        check_value("wr_ack", wr_ack, 1'b0);
        check_value("wr_ready", wr_ready, 1'b1);
        check_value("full", full, 1'b0);
        check_value("almost_full", almost_full, 1'b0);
        check_value("prog_full", prog_full, 1'b0);
        check_value("empty", empty, 1'b1);
        check_value("almost_empty", almost_empty, 1'b1);
        check_value("prog_empty", prog_empty, 1'b1);
        check_value("wr_data_count", wr_data_count, 0);
        check_value("rd_data_count", rd_data_count, 0);
        check_outputs();

        // first word into the empty fifo must show up on dout
        rng_state = xorshift32(rng_state);
        run_cycle(1'b1, 1'b0, rng_state);
        cycles = 0;
        while (!valid) begin
            if (cycles >= VALID_TIMEOUT) report_timeout("valid did not rise after a write");
            run_cycle(1'b0, 1'b0, '0);
            cycles++;
        end

        // phase 1, writes only
        cycles = 0;
        while (!full) begin
            if (cycles >= FILL_TIMEOUT) report_timeout("fifo never became full");
            rng_state = xorshift32(rng_state);
            run_cycle(1'b1, 1'b0, rng_state);
            cycles++;
        end
        // capacity is the ram depth plus the word in the output register
        check_value("writes accepted until full", writes_accepted, `FIFO_DEPTH + 1);
        // refused writes, overflow checked one cycle later
        repeat (3) begin
            rng_state = xorshift32(rng_state);
            run_cycle(1'b1, 1'b0, rng_state);
        end

        // phase 2, reads only
        cycles = 0;
        while (!empty) begin
            if (cycles >= DRAIN_TIMEOUT) report_timeout("fifo never drained in the read phase");
            run_cycle(1'b0, 1'b1, '0);
            cycles++;
        end
        // reads with nothing presented
        repeat (3) run_cycle(1'b0, 1'b1, '0);

        // phase 3, random traffic around 50 percent each side
        repeat (RANDOM_CYCLES) begin
            rng_state = xorshift32(rng_state);
            traffic = rng_state;
            rng_state = xorshift32(rng_state);
            run_cycle(traffic[3], traffic[11], rng_state);
        end

        // phase 4, final drain
        cycles = 0;
        while (!empty) begin
            if (cycles >= DRAIN_TIMEOUT) report_timeout("fifo never drained at the end");
            run_cycle(1'b0, 1'b1, '0);
            cycles++;
        end
        run_cycle(1'b0, 1'b0, '0);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 2;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // reset held over the first two rising edges, released on an edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

//--- design/fifo_width_down.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

module fifo_width_down import fifo_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         wr_en,
    input  wide_word_t   din,
    input  logic         rd_en,
    output logic         wr_ready,
    output logic         wr_ack,
    output logic         valid,
    output narrow_word_t dout,
    output logic         full,
    output logic         empty,
    output logic         almost_full,
    output logic         almost_empty,
    output logic         prog_full,
    output logic         prog_empty,
    output logic         overflow,
    output logic         underflow,
    output word_count_t  wr_data_count,
    output word_count_t  wr_data_space,
    output item_count_t  rd_data_count
);

    //////////////////////////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////////////////////////

    ram_wr_t ram_wr;
    word_ptr_t wr_ptr;
    logic ram_rd_en;
    logic [`FIFO_ADDR_BITS-1:0] ram_rd_addr;
    wide_word_t ram_rd_data;
    rd_progress_t progress;
    logic ram_empty;
    logic status_full;
    fifo_flags_t flags;

    //////////////////////////////////////////////////////////////////////
    // write side, storage, read side
    //////////////////////////////////////////////////////////////////////

    fifo_write_ctrl write_ctrl_i (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (wr_en),
        .din      (din),
        .full     (status_full),
        .wr_ready (wr_ready),
        .wr_ack   (wr_ack),
        .overflow (overflow),
        .wr       (ram_wr),
        .wr_ptr   (wr_ptr)
    );

    fifo_dpram dpram_i (
        .clock   (clock),
        .wr      (ram_wr),
        .rd_en   (ram_rd_en),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    fifo_read_ctrl read_ctrl_i (
        .clock       (clock),
        .reset       (reset),
        .rd_en       (rd_en),
        .ram_empty   (ram_empty),
        .ram_rd_data (ram_rd_data),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .progress    (progress),
        .valid       (valid),
        .underflow   (underflow),
        .dout        (dout)
    );

    // counts and flags straight from the pointers, no extra latency
    fifo_status status_i (
        .wr_ptr        (wr_ptr),
        .progress      (progress),
        .ram_empty     (ram_empty),
        .full          (status_full),
        .flags         (flags),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count)
    );

    // flag struct onto the top level pins
    assign full = flags.full;
    assign empty = flags.empty;
    assign almost_full = flags.almost_full;
    assign almost_empty = flags.almost_empty;
    assign prog_full = flags.prog_full;
    assign prog_empty = flags.prog_empty;

endmodule

//--- design/fifo_status.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

module fifo_status import fifo_pkg::*; (
    input  word_ptr_t    wr_ptr,
    input  rd_progress_t progress,
    output logic         ram_empty,
    output logic         full,
    output fifo_flags_t  flags,
    output word_count_t  wr_data_count,
    output word_count_t  wr_data_space,
    output item_count_t  rd_data_count
);

    // items still unread in the held word
    item_count_t held_items;

    //////////////////////////////////////////////////////////////////////
    // word side
    //////////////////////////////////////////////////////////////////////

    // words still in the ram, held word excluded
    // the wrap bit makes the 5 bit difference exact for 0..16
    assign wr_data_count = wr_ptr - progress.word_ptr;
    assign wr_data_space = word_count_t'(`FIFO_DEPTH) - wr_data_count;

    assign full = (wr_data_count == word_count_t'(`FIFO_DEPTH));
    assign ram_empty = (wr_data_count == '0);

    //////////////////////////////////////////////////////////////////////
    // item side
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (progress.state == hold_full) begin
            held_items = item_count_t'(`FIFO_LANES) - item_count_t'(progress.lane);
        end else begin
            held_items = '0;
        end
    end

    // four items per stored word plus what is left in the held one
    assign rd_data_count = item_count_t'({wr_data_count, 2'b00}) + held_items;

    //////////////////////////////////////////////////////////////////////
    // level flags
    //////////////////////////////////////////////////////////////////////

    assign flags.full = full;
    assign flags.empty = (rd_data_count == '0);
    // one more write would make it full
    assign flags.almost_full = (wr_data_count >= word_count_t'(`FIFO_DEPTH - 1));
    // at most one item left to read
    assign flags.almost_empty = (rd_data_count <= item_count_t'(1));
    assign flags.prog_full = (wr_data_count >= word_count_t'(`FIFO_PROG_FULL_THRESH));
    assign flags.prog_empty = (rd_data_count <= item_count_t'(`FIFO_PROG_EMPTY_THRESH));

    // writer and reader pointers live in different modules,
    // together they must never hold more than the ram depth
    always_comb begin
        assert final ($isunknown(wr_data_count)
                      || (wr_data_count <= word_count_t'(`FIFO_DEPTH)))
        else $error("word count above fifo depth");
    end

endmodule

//--- design/fifo_read_ctrl.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

module fifo_read_ctrl import fifo_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       rd_en,
    input  logic                       ram_empty,
    input  wide_word_t                 ram_rd_data,
    output logic                       ram_rd_en,
    output logic [`FIFO_ADDR_BITS-1:0] ram_rd_addr,
    output rd_progress_t               progress,
    output logic                       valid,
    output logic                       underflow,
    output narrow_word_t               dout
);

    // next word to fetch from the ram
    word_ptr_t rd_ptr;
    // item within the held word, 0 is the top byte
    lane_t lane;
    rd_state_e state;

    logic consume;
    logic last_lane;
    logic fetch;
    lane_t byte_sel;

    //////////////////////////////////////////////////////////////////////
    // fwft control
    //////////////////////////////////////////////////////////////////////

    // held word has at least one unread lane
    assign valid = (state == hold_full);
    assign consume = valid & rd_en;
    assign last_lane = (lane == lane_t'(`FIFO_LANES - 1));

    // refill when nothing is held, or when the last lane leaves this cycle
    // the second case keeps the stream gapless
    assign fetch = ~ram_empty & ((state == hold_empty) | (consume & last_lane));

    assign ram_rd_en = fetch;
    assign ram_rd_addr = rd_ptr[`FIFO_ADDR_BITS-1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            lane <= '0;
            state <= hold_empty;
        end else if (fetch) begin
            // ram output register takes the new word this edge
            rd_ptr <= rd_ptr + 1'b1;
            lane <= '0;
            state <= hold_full;
        end else if (consume) begin
            if (last_lane) begin
                lane <= '0;
                state <= hold_empty;
            end else begin
                lane <= lane + 1'b1;
            end
        end
    end

    // read attempted with nothing presented
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            underflow <= 1'b0;
        end else begin
            underflow <= rd_en & ~valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // lane select
    //////////////////////////////////////////////////////////////////////

    // msb first, lane 0 -> bits 31:24; with 4 lanes 3 - lane is ~lane
    assign byte_sel = ~lane;
    assign dout = ram_rd_data[byte_sel * `FIFO_OUT_WIDTH +: `FIFO_OUT_WIDTH];

    assign progress = '{
        word_ptr: rd_ptr,
        lane:     lane,
        state:    state
    };

    // a stalled reader keeps the presented item
    // this relies on the ram output register loading only on a fetch
    assert property (@(posedge clock) disable iff (reset)
        valid && !rd_en |=> valid && $stable(dout))
    else $error("held item changed while the reader stalled");

endmodule

//--- design/fifo_write_ctrl.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

module fifo_write_ctrl import fifo_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       wr_en,
    input  wide_word_t din,
    input  logic       full,
    output logic       wr_ready,
    output logic       wr_ack,
    output logic       overflow,
    output ram_wr_t    wr,
    output word_ptr_t  wr_ptr
);

    logic accept;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    // ready whenever there is room for one more word
    assign wr_ready = ~full;
    assign accept = wr_en & wr_ready;
    // ack is same cycle, not registered
    assign wr_ack = accept;

    // ram request, address is the pointer without its wrap bit
    assign wr = '{
        en:   accept,
        addr: wr_ptr[`FIFO_ADDR_BITS-1:0],
        data: din
    };

    //////////////////////////////////////////////////////////////////////
    // pointer and overflow
    //////////////////////////////////////////////////////////////////////

    // wraps naturally at 32, wrap bit tells full from empty
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (accept) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // refused write shows up one cycle later, for one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en & ~wr_ready;
        end
    end

    // full is computed in the status block from both pointers
    // it may only rise after an edge that wrote a word into the ram
    assert property (@(posedge clock) disable iff (reset)
        $rose(full) |-> $past(wr.en))
    else $error("full rose without a ram write");

endmodule

//--- design/fifo_dpram.sv
`timescale 1ns/1ns

`include "fifo_macros.svh"

module fifo_dpram import fifo_pkg::*; (
    input  logic                       clock,
    input  ram_wr_t                    wr,
    input  logic                       rd_en,
    input  logic [`FIFO_ADDR_BITS-1:0] rd_addr,
    output wide_word_t                 rd_data
);

    //////////////////////////////////////////////////////////////////////
    // storage array
    //////////////////////////////////////////////////////////////////////

    wide_word_t mem [0:`FIFO_DEPTH-1];

    // write port, one word per accepted write
    always_ff @(posedge clock) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    // output register only moves on a fetch
    // so it keeps presenting the word being split into lanes
    // a fetched address was always written at least one cycle earlier,
    // no read/write collision on the same word
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- design/fifo_pkg.sv
package fifo_pkg;

    `include "fifo_macros.svh"

    // payload types for both sides
    typedef logic [`FIFO_IN_WIDTH-1:0] wide_word_t;
    typedef logic [`FIFO_OUT_WIDTH-1:0] narrow_word_t;

    // word pointer carries one extra wrap bit above the address
    typedef logic [`FIFO_ADDR_BITS:0] word_ptr_t;
    typedef logic [`FIFO_LANE_BITS-1:0] lane_t;

    // 0..16 words in ram, 0..68 items incl. the held word
    typedef logic [`FIFO_ADDR_BITS:0] word_count_t;
    typedef logic [6:0] item_count_t;

    // does the ram output register hold a word not yet fully read
    typedef enum logic {
        hold_empty,
        hold_full
    } rd_state_e;

    // ram write request
    typedef struct packed {
        logic en;
        logic [`FIFO_ADDR_BITS-1:0] addr;
        wide_word_t data;
    } ram_wr_t;

    // read side position as seen by the status logic
    typedef struct packed {
        word_ptr_t word_ptr;
        lane_t lane;
        rd_state_e state;
    } rd_progress_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic almost_full;
        logic almost_empty;
        logic prog_full;
        logic prog_empty;
    } fifo_flags_t;

endpackage

//--- include/fifo_macros.svh
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////////////////////////

// one write word
`define FIFO_IN_WIDTH 32
// one read item
`define FIFO_OUT_WIDTH 8
// read items per write word, lane index width
`define FIFO_LANES 4
`define FIFO_LANE_BITS 2

//////////////////////////////////////////////////////////////////////
// storage and thresholds
//////////////////////////////////////////////////////////////////////

// depth in wide words, address width without the wrap bit
`define FIFO_DEPTH 16
`define FIFO_ADDR_BITS 4
// prog_full compares words, prog_empty compares items
`define FIFO_PROG_FULL_THRESH 12
`define FIFO_PROG_EMPTY_THRESH 6

`endif
